//--- source/dcache_pkg.sv
package dcache_pkg;

    // word and line geometry
    localparam int WORD_BITS   = 32;
    localparam int WORD_BYTES  = WORD_BITS / 8;
    localparam int OFFSET_BITS = 2;
    localparam int INDEX_BITS  = 2;
    localparam int WAY_BITS    = 2;
    localparam int ZERO_BITS   = $clog2(WORD_BYTES);
    localparam int TAG_BITS    = WORD_BITS - INDEX_BITS - OFFSET_BITS - ZERO_BITS;

    localparam int NUM_WORDS = 2 ** OFFSET_BITS;
    localparam int NUM_SETS  = 2 ** INDEX_BITS;
    localparam int NUM_WAYS  = 2 ** WAY_BITS;

    // one node per inner vertex of the binary tree over the ways
    localparam int PLRU_BITS = NUM_WAYS - 1;

    // data RAM word address is {way, set, word}
    localparam int RAM_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;

    typedef logic [WORD_BITS-1:0]   word_t;
    typedef logic [WORD_BYTES-1:0]  byte_en_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [WAY_BITS-1:0]    way_t;

    typedef struct packed {
        tag_t                 tag;
        index_t               index;
        offset_t              offset;
        logic [ZERO_BITS-1:0] zeros;
    } cache_addr_fields_t;

    // same word, seen flat or split into cache fields
    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        cache_addr_fields_t   fields;
    } cache_addr_u;

    // refill always writes whole words
    localparam byte_en_t FULL_MASK = '1;

endpackage

//--- source/dcache_meta_store.sv
module dcache_meta_store (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  dcache_pkg::index_t                          index,
    input  logic                                        wr_en,
    input  dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0] new_tags,
    input  logic [dcache_pkg::NUM_WAYS-1:0]             new_valid,
    input  logic [dcache_pkg::NUM_WAYS-1:0]             new_dirty,
    input  logic [dcache_pkg::PLRU_BITS-1:0]            new_plru,
    output dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0] tags,
    output logic [dcache_pkg::NUM_WAYS-1:0]             valid,
    output logic [dcache_pkg::NUM_WAYS-1:0]             dirty,
    output logic [dcache_pkg::PLRU_BITS-1:0]            plru
);
    import dcache_pkg::*;

    // one record per set
    tag_t [NUM_WAYS-1:0]  tags_q  [NUM_SETS];
    logic [NUM_WAYS-1:0]  valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0]  dirty_q [NUM_SETS];
    logic [PLRU_BITS-1:0] plru_q  [NUM_SETS];

    // asynchronous read of the addressed set
    assign tags  = tags_q[index];
    assign valid = valid_q[index];
    assign dirty = dirty_q[index];
    assign plru  = plru_q[index];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else if (wr_en) begin
            valid_q[index] <= new_valid;
            dirty_q[index] <= new_dirty;
            plru_q[index]  <= new_plru;
        end
    end

    // tag fields of the addressed set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags_q[index] <= new_tags;
        end
    end

endmodule

//--- source/dcache_plru.sv
module dcache_plru (
    input  logic [dcache_pkg::PLRU_BITS-1:0] tree,
    input  dcache_pkg::way_t                 hit_way,
    output dcache_pkg::way_t                 victim,
    output logic [dcache_pkg::PLRU_BITS-1:0] new_tree
);
    import dcache_pkg::*;

    // tree[0] picks the half, tree[1] ways 0/1, tree[2] ways 2/3
    function automatic way_t walk(input logic [PLRU_BITS-1:0] t);
        way_t w;
        w[1] = t[0];
        w[0] = t[0] ? t[2] : t[1];
        return w;
    endfunction

    assign victim = walk(tree);

    // point every node on the path away from the accessed way
    always_comb begin
        new_tree    = tree;
        new_tree[0] = ~hit_way[1];
        if (hit_way[1]) begin
            new_tree[2] = ~hit_way[0];
        end else begin
            new_tree[1] = ~hit_way[0];
        end
    end

endmodule

//--- source/dcache_way_match.sv
module dcache_way_match (
    input  dcache_pkg::tag_t                            tag,
    input  dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0] way_tags,
    input  logic [dcache_pkg::NUM_WAYS-1:0]             way_valid,
    output logic                                        hit,
    output dcache_pkg::way_t                            hit_way
);
    import dcache_pkg::*;

    logic [NUM_WAYS-1:0] hit_vec;

    // all ways compared in parallel
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = way_valid[w] && way_tags[w] == tag;
        end
    end

    assign hit = |hit_vec;

    // OR of the matching indices, exact for a one-hot vector
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = hit_way | way_t'(w);
            end
        end
    end

    // a tag is installed only on a miss, so at most one way may match
    always_comb begin
        way_hit_onehot: assert final ($isunknown(hit_vec) || $onehot0(hit_vec));
    end

endmodule

//--- source/dcache_data_ram.sv
module dcache_data_ram (
    input  logic                                 clk,
    input  logic                                 en_1,
    input  dcache_pkg::byte_en_t                 byte_en_1,
    input  logic [dcache_pkg::RAM_ADDR_BITS-1:0] addr_1,
    input  dcache_pkg::word_t                    wdata_1,
    output dcache_pkg::word_t                    rdata_1,
    input  dcache_pkg::byte_en_t                 byte_en_2,
    input  logic [dcache_pkg::RAM_ADDR_BITS-1:0] addr_2,
    input  dcache_pkg::word_t                    wdata_2,
    output dcache_pkg::word_t                    rdata_2
);
    import dcache_pkg::*;

    word_t mem [2 ** RAM_ADDR_BITS];

    // read-first on both ports: the old word is read before the new bytes land
    always_ff @(posedge clk) begin
        if (en_1) begin
            rdata_1 <= mem[addr_1];
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (byte_en_1[b]) begin
                    mem[addr_1][8*b +: 8] <= wdata_1[8*b +: 8];
                end
            end
        end

        // port 2 always runs, it feeds the victim buffer
        rdata_2 <= mem[addr_2];
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (byte_en_2[b]) begin
                mem[addr_2][8*b +: 8] <= wdata_2[8*b +: 8];
            end
        end
    end

    // hits only write words whose refill beat has already landed
    ram_no_write_clash: assert property (@(posedge clk)
        !(en_1 && (|byte_en_1) && (|byte_en_2) && addr_1 == addr_2));

endmodule

//--- source/dcache_victim_buffer.sv
module dcache_victim_buffer (
    input  logic                 clk,
    input  logic                 capture,
    input  dcache_pkg::offset_t  capture_offset,
    input  dcache_pkg::word_t    word_in,
    input  dcache_pkg::offset_t  read_offset,
    output dcache_pkg::word_t    word_out
);
    import dcache_pkg::*;

    // old line, filled one word per refill beat
    word_t line [NUM_WORDS];

    always_ff @(posedge clk) begin
        if (capture) begin
            line[capture_offset] <= word_in;
        end
    end

    // writeback beat picks the word
    assign word_out = line[read_offset];

endmodule

//--- source/dcache_miss_ctrl.sv
module dcache_miss_ctrl (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  logic                                        req,
    input  logic                                        is_write,
    input  dcache_pkg::cache_addr_u                     addr,
    input  logic                                        hit,
    input  dcache_pkg::way_t                            hit_way,
    input  dcache_pkg::way_t                            victim,
    input  dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0] tags,
    input  logic [dcache_pkg::NUM_WAYS-1:0]             valid,
    input  logic [dcache_pkg::NUM_WAYS-1:0]             dirty,
    input  logic [dcache_pkg::PLRU_BITS-1:0]            new_plru,
    input  logic                                        mem_okay,
    input  logic                                        mem_last,
    output logic                                        addr_ok,
    output logic                                        data_ok,
    output logic                                        ram_en_1,
    output logic [dcache_pkg::RAM_ADDR_BITS-1:0]        ram_addr_1,
    output logic [dcache_pkg::RAM_ADDR_BITS-1:0]        ram_addr_2,
    output dcache_pkg::byte_en_t                        refill_en,
    output logic                                        capture,
    output dcache_pkg::offset_t                         capture_offset,
    output dcache_pkg::offset_t                         wb_offset,
    output logic                                        meta_wr_en,
    output dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0] new_tags,
    output logic [dcache_pkg::NUM_WAYS-1:0]             new_valid,
    output logic [dcache_pkg::NUM_WAYS-1:0]             new_dirty,
    output logic [dcache_pkg::PLRU_BITS-1:0]            out_plru,
    output logic                                        mem_valid,
    output logic                                        mem_is_write,
    output dcache_pkg::cache_addr_u                     mem_addr
);
    import dcache_pkg::*;

    enum logic [1:0] {IDLE, READ, WRITE} state;

    // line under refill
    tag_t                miss_tag;
    index_t              miss_index;
    way_t                miss_way;
    offset_t             beat;
    logic [NUM_WORDS-1:0] ready;

    // displaced line
    tag_t victim_tag;
    logic victim_dirty;

    logic req_in_miss;
    logic req_ready;
    logic miss_avail;
    logic req_to_hit;
    logic req_to_miss;
    way_t req_way;

    // a request into the refilling line waits for its own word only
    assign req_in_miss = state == READ && addr.fields.tag == miss_tag
                         && addr.fields.index == miss_index;
    assign req_ready   = !req_in_miss || ready[addr.fields.offset];

    // next miss may overlap the final writeback beat
    assign miss_avail  = state == IDLE || (state == WRITE && mem_okay && mem_last);

    assign req_to_hit  = req && hit && req_ready;
    assign req_to_miss = req && !hit && miss_avail;

    // victim way on a miss, so the tree update points away from it too
    assign req_way = hit ? hit_way : victim;

    assign addr_ok    = req_to_hit;
    assign ram_en_1   = req_to_hit;
    assign ram_addr_1 = {req_way, addr.fields.index, addr.fields.offset};
    assign ram_addr_2 = {miss_way, miss_index, beat};
    assign refill_en  = (state == READ && mem_okay) ? FULL_MASK : '0;
    assign wb_offset  = beat;

    // set record written back on every accepted hit and every started miss
    always_comb begin
        meta_wr_en = req_to_hit || req_to_miss;
        new_tags   = tags;
        new_valid  = valid;
        new_dirty  = dirty;
        out_plru   = new_plru;
        if (req_to_miss) begin
            new_tags[victim]  = addr.fields.tag;
            new_valid[victim] = 1'b1;
            new_dirty[victim] = 1'b0;
        end else if (req_to_hit && is_write) begin
            new_dirty[hit_way] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= IDLE;
            beat    <= '0;
            ready   <= '0;
            data_ok <= 1'b0;
            capture <= 1'b0;
        end else begin
            data_ok <= req_to_hit;
            // old word leaves port 2 one cycle after its refill beat
            capture <= state == READ && mem_okay;

            case (state)
                READ: begin
                    if (mem_okay) begin
                        beat        <= offset_t'(beat + 1'b1);
                        ready[beat] <= 1'b1;
                        if (mem_last) begin
                            state <= victim_dirty ? WRITE : IDLE;
                        end
                    end
                end
                WRITE: begin
                    if (mem_okay) begin
                        beat <= offset_t'(beat + 1'b1);
                        if (mem_last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            if (req_to_miss) begin
                state <= READ;
                beat  <= '0;
                ready <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        capture_offset <= beat;
        if (req_to_miss) begin
            miss_tag     <= addr.fields.tag;
            miss_index   <= addr.fields.index;
            miss_way     <= victim;
            victim_tag   <= tags[victim];
            victim_dirty <= valid[victim] && dirty[victim];
        end
    end

    assign mem_valid    = state != IDLE;
    assign mem_is_write = state == WRITE;

    // line-aligned burst address, victim tag during writeback
    always_comb begin
        mem_addr.fields.tag    = state == WRITE ? victim_tag : miss_tag;
        mem_addr.fields.index  = miss_index;
        mem_addr.fields.offset = '0;
        mem_addr.fields.zeros  = '0;
    end

    mem_addr_stable: assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !mem_okay |=> mem_valid && $stable(mem_addr.raw));

endmodule

//--- source/dcache_top.sv
module dcache_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    req,
    input  logic                    is_write,
    input  dcache_pkg::cache_addr_u addr,
    input  dcache_pkg::byte_en_t    byte_en,
    input  dcache_pkg::word_t       wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output dcache_pkg::word_t       rdata,
    output logic                    mem_valid,
    output logic                    mem_is_write,
    output dcache_pkg::cache_addr_u mem_addr,
    output dcache_pkg::word_t       mem_wdata,
    input  logic                    mem_okay,
    input  logic                    mem_last,
    input  dcache_pkg::word_t       mem_rdata
);
    import dcache_pkg::*;

    // set record
    tag_t [NUM_WAYS-1:0]  tags;
    logic [NUM_WAYS-1:0]  valid;
    logic [NUM_WAYS-1:0]  dirty;
    logic [PLRU_BITS-1:0] plru_tree;
    tag_t [NUM_WAYS-1:0]  new_tags;
    logic [NUM_WAYS-1:0]  new_valid;
    logic [NUM_WAYS-1:0]  new_dirty;
    logic [PLRU_BITS-1:0] updated_tree;
    logic [PLRU_BITS-1:0] store_tree;
    logic                 meta_wr_en;

    logic hit;
    way_t hit_way;
    way_t victim;

    // data path
    logic                     ram_en_1;
    logic [RAM_ADDR_BITS-1:0] ram_addr_1;
    logic [RAM_ADDR_BITS-1:0] ram_addr_2;
    byte_en_t                 refill_en;
    word_t                    victim_word;
    logic                     capture;
    offset_t                  capture_offset;
    offset_t                  wb_offset;

    dcache_meta_store meta_store (
        .clk, .resetn,
        .index(addr.fields.index),
        .wr_en(meta_wr_en),
        .new_tags, .new_valid, .new_dirty,
        .new_plru(store_tree),
        .tags, .valid, .dirty,
        .plru(plru_tree)
    );

    // tree update follows the accessed way, taken from the port 1 address
    dcache_plru plru (
        .tree(plru_tree),
        .hit_way(ram_addr_1[RAM_ADDR_BITS-1 -: WAY_BITS]),
        .victim,
        .new_tree(updated_tree)
    );

    dcache_way_match way_match (
        .tag(addr.fields.tag),
        .way_tags(tags),
        .way_valid(valid),
        .hit, .hit_way
    );

    // byte_en is zero on reads, so a read hit leaves the word untouched
    dcache_data_ram data_ram (
        .clk,
        .en_1(ram_en_1), .byte_en_1(byte_en), .addr_1(ram_addr_1),
        .wdata_1(wdata), .rdata_1(rdata),
        .byte_en_2(refill_en), .addr_2(ram_addr_2),
        .wdata_2(mem_rdata), .rdata_2(victim_word)
    );

    dcache_victim_buffer victim_buffer (
        .clk, .capture, .capture_offset,
        .word_in(victim_word),
        .read_offset(wb_offset),
        .word_out(mem_wdata)
    );

    dcache_miss_ctrl miss_ctrl (
        .clk, .resetn, .req, .is_write, .addr,
        .hit, .hit_way, .victim, .tags, .valid, .dirty,
        .new_plru(updated_tree),
        .mem_okay, .mem_last,
        .addr_ok, .data_ok,
        .ram_en_1, .ram_addr_1, .ram_addr_2, .refill_en,
        .capture, .capture_offset, .wb_offset,
        .meta_wr_en, .new_tags, .new_valid, .new_dirty,
        .out_plru(store_tree),
        .mem_valid, .mem_is_write, .mem_addr
    );

endmodule

//--- test/dcache_tb.sv
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    localparam TEST_FILE = "test/dcache_testdata.txt";
    localparam int RESET_CYCLES = 10;
    localparam int CYCLES_PER_REQUEST = 400;
    localparam int MEM_WORDS = 16384;
    localparam word_t MEM_PATTERN = 32'hA5A5_0000;

    logic        clk;
    logic        resetn;
    logic        req;
    logic        is_write;
    cache_addr_u addr;
    byte_en_t    byte_en;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        mem_valid;
    logic        mem_is_write;
    cache_addr_u mem_addr;
    word_t       mem_wdata;
    logic        mem_okay;
    logic        mem_last;
    word_t       mem_rdata;

    // test list, one entry per line of the data file
    string    name_q [$];
    string    op_q [$];
    word_t    addr_q [$];
    byte_en_t be_q [$];
    word_t    wdata_q [$];
    word_t    expect_q [$];

    // memory model
    word_t       mem_words [MEM_WORDS];
    cache_addr_u wb_q [$];
    int          beat_cnt;
    logic        stall_done;
    logic        burst_end;
    logic        stall_now;
    word_t       beat_addr;

    int data_errors = 0;
    int wb_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    dcache_top DUT (
        .clk, .resetn, .req, .is_write, .addr, .byte_en, .wdata,
        .addr_ok, .data_ok, .rdata,
        .mem_valid, .mem_is_write, .mem_addr, .mem_wdata,
        .mem_okay, .mem_last, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            data_errors++;
            $display("ERR %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_wb_addr(input string name, input cache_addr_u expected,
                                 input cache_addr_u actual);
        if (actual.raw !== expected.raw) begin
            wb_errors++;
            $display("ERR %s: expected %08h, actual %08h", name, expected.raw, actual.raw);
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    n;
        string tok;
        string op;
        string rest;
        word_t a;
        word_t be_word;
        word_t wd;
        word_t ex;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the test data file %s", TEST_FILE);
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%s", op);
                be_word = '0;
                wd = '0;
                ex = '0;
                if (op == "B") begin
                    n = $fscanf(fd, "%h", a);
                end else begin
                    n = $fscanf(fd, "%h %h %h %h", a, be_word, wd, ex);
                end
                name_q.push_back(tok);
                op_q.push_back(op);
                addr_q.push_back(a);
                be_q.push_back(byte_en_t'(be_word));
                wdata_q.push_back(wd);
                expect_q.push_back(ex);
            end
        end
        $fclose(fd);
    endtask

    // hold the request until addr_ok, then expect data_ok in the next cycle
    task automatic run_request(input int i);
        req      <= 1'b1;
        is_write <= op_q[i] == "W";
        addr.raw <= addr_q[i];
        byte_en  <= be_q[i];
        wdata    <= wdata_q[i];
        @(posedge clk);
        while (addr_ok !== 1'b1) begin
            if (data_ok === 1'b1) begin
                other_errors++;
                $display("%s: data_ok came before the request was accepted", name_q[i]);
            end
            @(posedge clk);
        end
        req     <= 1'b0;
        byte_en <= '0;
        @(posedge clk);
        if (data_ok !== 1'b1) begin
            other_errors++;
            $display("%s: data_ok did not come one cycle after acceptance", name_q[i]);
        end else begin
            check_word(name_q[i], expect_q[i], rdata);
        end
    endtask

    task automatic check_writeback(input int i);
        cache_addr_u expected;
        expected.raw = addr_q[i];
        while (wb_q.size() == 0) begin
            @(posedge clk);
        end
        check_wb_addr(name_q[i], expected, wb_q.pop_front());
    endtask

    task automatic end_run();
        $display("errors: data %0d, writeback %0d, other %0d",
                 data_errors, wb_errors, other_errors);
        if (data_errors + wb_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // burst responder, a gap cycle after every burst
    always @(posedge clk) begin
        if (resetn) begin
            mem_okay   <= 1'b0;
            mem_last   <= 1'b0;
            mem_rdata  <= '0;
            beat_cnt   = 0;
            stall_done = 1'b0;
        end else begin
            burst_end = 1'b0;
            beat_addr = mem_addr.raw + WORD_BYTES * beat_cnt;
            if (mem_valid && mem_okay) begin
                if (mem_is_write) begin
                    if (beat_cnt == 0) begin
                        wb_q.push_back(mem_addr);
                    end
                    mem_words[beat_addr[15:2]] = mem_wdata;
                end
                burst_end = beat_cnt == NUM_WORDS - 1;
                beat_cnt = burst_end ? 0 : beat_cnt + 1;
                if (burst_end) begin
                    stall_done = 1'b0;
                end
            end
            beat_addr = mem_addr.raw + WORD_BYTES * beat_cnt;
            // odd line addresses pause once before the third beat
            stall_now = mem_valid && mem_addr.raw[4] && beat_cnt == 2 && !stall_done;
            if (mem_valid && !burst_end && !stall_now) begin
                mem_okay  <= 1'b1;
                mem_last  <= beat_cnt == NUM_WORDS - 1;
                mem_rdata <= mem_words[beat_addr[15:2]];
            end else begin
                mem_okay <= 1'b0;
                mem_last <= 1'b0;
                if (stall_now) begin
                    stall_done = 1'b1;
                end
            end
        end
    end

    initial begin
        int n_requests;
        n_requests = 0;
        resetn    = 1'b1;
        req       = 1'b0;
        is_write  = 1'b0;
        addr      = '0;
        byte_en   = '0;
        wdata     = '0;
        mem_okay  = 1'b0;
        mem_last  = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = word_t'(i * WORD_BYTES) ^ MEM_PATTERN;
        end
        load_tests();
        foreach (op_q[i]) begin
            if (op_q[i] != "B") begin
                n_requests++;
            end
        end
        cycle_limit = CYCLES_PER_REQUEST * n_requests + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < name_q.size(); i++) begin
            if (op_q[i] == "B") begin
                check_writeback(i);
            end else begin
                run_request(i);
            end
        end
        // a writeback may still be running
        while (mem_valid !== 1'b0) begin
            @(posedge clk);
        end
        if (wb_q.size() != 0) begin
            other_errors += wb_q.size();
            $display("%0d writeback bursts came that the test list does not expect", wb_q.size());
        end
        end_run();
    end

    initial begin
        wait (cycle_limit > 0);
        wait (cycle_count >= cycle_limit);
        other_errors++;
        $display("run stopped after %0d cycles before the test list was done", cycle_count);
        end_run();
    end

endmodule

//--- test/dcache_testdata.txt
# request: name R|W addr byte_en wdata expected_rdata (hex, rdata of a write is the old word)
# writeback: name B expected writeback line address (hex)
rd_miss_first R 00001008 0 00000000 a5a51008
rd_same_line R 00001000 0 00000000 a5a51000
rd_hit_c R 0000100c 0 00000000 a5a5100c
rd_hit_repeat R 00001008 0 00000000 a5a51008
wr_low_half W 00001004 3 12345678 a5a51004
rd_low_half R 00001004 0 00000000 a5a55678
wr_high_half W 00001004 c dead0000 a5a55678
rd_high_half R 00001004 0 00000000 dead5678
set1_wr_way0 W 00002010 f 11111111 a5a52010
set1_rd_way2 R 00003014 0 00000000 a5a53014
set1_wr_way1 W 00004018 f 22222222 a5a54018
set1_rd_way3 R 0000501c 0 00000000 a5a5501c
set1_evict_a R 00006010 0 00000000 a5a56010
set1_evict_a B 00002010
set1_reload_a R 00002010 0 00000000 11111111
set1_reload_a2 R 00002014 0 00000000 a5a52014
set1_evict_b R 00003010 0 00000000 a5a53010
set1_evict_b B 00004010
set1_reload_b R 00004018 0 00000000 22222222
set1_reload_b2 R 00004010 0 00000000 a5a54010
set0_fill_way2 R 00007000 0 00000000 a5a57000
set0_fill_way1 R 00008004 0 00000000 a5a58004
set0_fill_way3 R 00009008 0 00000000 a5a59008
set0_evict R 0000a00c 0 00000000 a5a5a00c
set0_evict B 00001000
set0_reload R 00001004 0 00000000 dead5678
set0_reload2 R 00001000 0 00000000 a5a51000
set0_reload3 R 0000100c 0 00000000 a5a5100c

//--- vlog.f
source/dcache_pkg.sv
source/dcache_meta_store.sv
source/dcache_plru.sv
source/dcache_way_match.sv
source/dcache_data_ram.sv
source/dcache_victim_buffer.sv
source/dcache_miss_ctrl.sv
source/dcache_top.sv
test/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - source/dcache_pkg.sv
      - source/dcache_meta_store.sv
      - source/dcache_plru.sv
      - source/dcache_way_match.sv
      - source/dcache_data_ram.sv
      - source/dcache_victim_buffer.sv
      - source/dcache_miss_ctrl.sv
      - source/dcache_top.sv
  - target: test
    files:
      - test/dcache_tb.sv
